// File: design/coeff_lane_encoder.sv
// Lane encoder that maps four coefficients to 3-bit eta codes
// and flags any coefficient outside the legal set.

`timescale 1ns/100ps

module coeff_lane_encoder (
    input  skencode_pkg::coeff_quad_t coeffs,
    output skencode_pkg::lane_code_t  codes,
    output logic                      err
);

    logic [3:0] bad;

    // The eta = 2 rule stores 2 - c, with negative values taken modulo q.
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            bad[i] = 1'b0;
            case (coeffs[i])
                skencode_pkg::coeff_w'(0): begin
                    codes[i] = 3'd2;
                end
                skencode_pkg::coeff_w'(1): begin
                    codes[i] = 3'd1;
                end
                skencode_pkg::coeff_w'(2): begin
                    codes[i] = 3'd0;
                end
                skencode_pkg::coeff_w'(skencode_pkg::mldsa_q - 1): begin
                    codes[i] = 3'd3;
                end
                skencode_pkg::coeff_w'(skencode_pkg::mldsa_q - 2): begin
                    codes[i] = 3'd4;
                end
                default: begin
                    // Out of range, so the code is forced to zero.
                    codes[i] = 3'd0;
                    bad[i]   = 1'b1;
                end
            endcase
        end
    end

    assign err = |bad;

endmodule

// File: design/key_word_packer.sv
// Packer that collects 24-bit code strings into a 96-bit buffer
// and writes it to key memory as three 32-bit words.

`timescale 1ns/100ps

module key_word_packer (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              zeroize,
    input  logic [skencode_pkg::addr_w-1:0]   dest_base,
    input  logic                              data_valid,
    input  logic                              abort,
    input  skencode_pkg::lane_code_t          codes_a,
    input  skencode_pkg::lane_code_t          codes_b,
    output skencode_pkg::mem_req_t            wr_req,
    output logic [skencode_pkg::word_w-1:0]   wr_data,
    output logic                              pack_last
);

    logic [skencode_pkg::buf_w-1:0]                   buf_q;
    logic [skencode_pkg::str_w-1:0]                   lane_str;
    logic [1:0]                                       prod_idx;
    logic [1:0]                                       cons_idx;
    logic                                             cons_busy;
    logic                                             run_active;
    logic [$clog2(skencode_pkg::num_wr_words+1)-1:0]  word_cnt;
    logic [skencode_pkg::addr_w-1:0]                  dest_lock;
    logic [skencode_pkg::addr_w-1:0]                  wr_addr;
    logic                                             group_done;
    logic                                             run_end;

    // Lane A fills the low half of each string.
    assign lane_str   = {codes_b, codes_a};
    assign group_done = data_valid && (prod_idx == 2'd3);
    assign wr_addr    = dest_lock +
                        {{(skencode_pkg::addr_w - $bits(word_cnt)){1'b0}}, word_cnt};

    // The last word of the image is on the bus once the counter has wrapped to the end.
    assign run_end = (wr_req.op == skencode_pkg::mem_write) &&
                     (int'(word_cnt) == skencode_pkg::num_wr_words);

    // ==================================================
    // Producer side
    // ==================================================
    always_ff @(posedge clk) begin
        if (data_valid) begin
            buf_q[prod_idx * skencode_pkg::str_w +: skencode_pkg::str_w] <= lane_str;
        end
        if (data_valid && !run_active) begin
            dest_lock <= dest_base;
        end
    end

    // ==================================================
    // Consumer side
    // ==================================================

    // A slice is still intact while it is on the bus, since the next group only
    // overwrites string k one cycle after word k has gone out.
    always_comb begin
        case (cons_idx)
            2'd0: wr_data = buf_q[0 +: skencode_pkg::word_w];
            2'd1: wr_data = buf_q[skencode_pkg::word_w +: skencode_pkg::word_w];
            2'd2: wr_data = buf_q[2 * skencode_pkg::word_w +: skencode_pkg::word_w];
            default: wr_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_idx   <= '0;
            cons_idx   <= '0;
            cons_busy  <= 1'b0;
            run_active <= 1'b0;
            word_cnt   <= '0;
            wr_req     <= skencode_pkg::mem_req_idle;
            pack_last  <= 1'b0;
        end
        else if (zeroize || abort) begin
            prod_idx   <= '0;
            cons_idx   <= '0;
            cons_busy  <= 1'b0;
            run_active <= 1'b0;
            word_cnt   <= '0;
            wr_req     <= skencode_pkg::mem_req_idle;
            pack_last  <= 1'b0;
        end
        else begin
            pack_last <= run_end;

            if (data_valid) begin
                prod_idx   <= prod_idx + 1'b1;
                run_active <= 1'b1;
            end

            // A full group arms the consumer, which then sends three words back to back.
            if (group_done) begin
                wr_req    <= '{op: skencode_pkg::mem_write, addr: wr_addr};
                cons_idx  <= 2'd0;
                cons_busy <= 1'b1;
                word_cnt  <= word_cnt + 1'b1;
            end
            else if (cons_busy) begin
                wr_req   <= '{op: skencode_pkg::mem_write, addr: wr_addr};
                cons_idx <= cons_idx + 1'b1;
                word_cnt <= word_cnt + 1'b1;
                if (cons_idx == 2'd1) begin
                    cons_busy <= 1'b0;
                end
            end
            else begin
                wr_req <= skencode_pkg::mem_req_idle;
            end

            if (run_end) begin
                word_cnt   <= '0;
                run_active <= 1'b0;
                prod_idx   <= '0;
            end
        end
    end

endmodule

// File: design/skencode_ctrl.sv
// Sequencer for the secret-key encoder: paired coefficient reads,
// lane error qualification, and the done and error pulses.

`timescale 1ns/100ps

module skencode_ctrl (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              zeroize,
    input  logic                              enable,
    input  logic [skencode_pkg::addr_w-1:0]   src_base,
    input  logic                              err_a,
    input  logic                              err_b,
    input  logic                              pack_last,
    output skencode_pkg::mem_req_t            rd_req_a,
    output skencode_pkg::mem_req_t            rd_req_b,
    output logic                              data_valid,
    output logic                              abort,
    output logic                              done,
    output logic                              error
);

    skencode_pkg::ctrl_state_e state;
    skencode_pkg::ctrl_state_e next_state;

    logic [$clog2(skencode_pkg::num_rd_pairs)-1:0] pair_cnt;
    logic [skencode_pkg::addr_w-1:0]               locked_src;
    logic [skencode_pkg::addr_w-1:0]               rd_base;
    logic [skencode_pkg::addr_w-1:0]               pair_off;
    logic [skencode_pkg::addr_w-1:0]               pair_addr;
    logic                                          issue_rd;
    logic                                          bad_hit;

    // ==================================================
    // Read addressing
    // ==================================================

    // The first pair goes out in the enable cycle, before the lock has settled.
    assign rd_base  = (state == skencode_pkg::st_idle) ? src_base : locked_src;
    assign pair_off = {{(skencode_pkg::addr_w - $bits(pair_cnt) - 1){1'b0}}, pair_cnt, 1'b0};
    assign pair_addr = rd_base + pair_off;

    assign issue_rd = ((state == skencode_pkg::st_idle) && enable) ||
                      (state == skencode_pkg::st_read);

    // Lane flags are only meaningful while returned data is valid.
    assign bad_hit = data_valid & (err_a | err_b);

    always_ff @(posedge clk) begin
        if ((state == skencode_pkg::st_idle) && enable) begin
            locked_src <= src_base;
        end
    end

    // ==================================================
    // State machine
    // ==================================================
    always_comb begin
        next_state = state;
        case (state)
            skencode_pkg::st_idle: begin
                if (enable) begin
                    next_state = skencode_pkg::st_read;
                end
            end
            skencode_pkg::st_read: begin
                if (int'(pair_cnt) == skencode_pkg::num_rd_pairs - 1) begin
                    next_state = skencode_pkg::st_drain;
                end
            end
            skencode_pkg::st_drain: begin
                // The last pair's data comes back in the next cycle.
                next_state = skencode_pkg::st_wait_pack;
            end
            skencode_pkg::st_wait_pack: begin
                if (pack_last) begin
                    next_state = skencode_pkg::st_done;
                end
            end
            skencode_pkg::st_done: begin
                next_state = skencode_pkg::st_idle;
            end
            default: begin
                next_state = skencode_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= skencode_pkg::st_idle;
            pair_cnt   <= '0;
            rd_req_a   <= skencode_pkg::mem_req_idle;
            rd_req_b   <= skencode_pkg::mem_req_idle;
            data_valid <= 1'b0;
            abort      <= 1'b0;
            done       <= 1'b0;
            error      <= 1'b0;
        end
        else if (zeroize || bad_hit) begin
            // An invalid coefficient ends the run the same way a zeroize does,
            // except that it is reported and the packer is told to drop its state.
            state      <= skencode_pkg::st_idle;
            pair_cnt   <= '0;
            rd_req_a   <= skencode_pkg::mem_req_idle;
            rd_req_b   <= skencode_pkg::mem_req_idle;
            data_valid <= 1'b0;
            abort      <= bad_hit & ~zeroize;
            done       <= 1'b0;
            error      <= bad_hit & ~zeroize;
        end
        else begin
            state      <= next_state;
            abort      <= 1'b0;
            error      <= 1'b0;
            done       <= (state == skencode_pkg::st_wait_pack) && pack_last;
            data_valid <= (rd_req_a.op == skencode_pkg::mem_read);

            if (issue_rd) begin
                rd_req_a <= '{op: skencode_pkg::mem_read, addr: pair_addr};
                rd_req_b <= '{op: skencode_pkg::mem_read, addr: pair_addr + 1'b1};
                pair_cnt <= pair_cnt + 1'b1;
            end
            else begin
                rd_req_a <= skencode_pkg::mem_req_idle;
                rd_req_b <= skencode_pkg::mem_req_idle;
                pair_cnt <= '0;
            end
        end
    end

endmodule

// File: design/skencode_pkg.sv
// Shared sizes, memory request type, coefficient and code arrays,
// and the controller state encoding for the secret-key encoder.

package skencode_pkg;

    // ==================================================
    // Sizes
    // ==================================================
    localparam int addr_w  = 15;
    localparam int coeff_w = 24;
    localparam int code_w  = 3;
    localparam int word_w  = 32;

    localparam int mldsa_q = 8380417;
    localparam int mldsa_l = 7;
    localparam int mldsa_k = 8;
    localparam int mldsa_n = 256;

    // Each address holds four coefficients, and a read cycle covers two addresses.
    localparam int num_rd_addr  = ((mldsa_l + mldsa_k) * mldsa_n) / 4;
    localparam int num_rd_pairs = num_rd_addr / 2;
    localparam int num_wr_words = ((mldsa_l + mldsa_k) * mldsa_n * code_w) / word_w;

    // One packed string holds both lanes, and four strings fill the buffer.
    localparam int str_w = 2 * 4 * code_w;
    localparam int buf_w = 4 * str_w;

    // ==================================================
    // Types
    // ==================================================
    typedef enum logic [1:0] {
        mem_idle,
        mem_read,
        mem_write
    } mem_op_e;

    typedef struct packed {
        mem_op_e             op;
        logic [addr_w-1:0]   addr;
    } mem_req_t;

    localparam mem_req_t mem_req_idle = '{op: mem_idle, addr: '0};

    // Each memory address holds four coefficients with coefficient 0 in the low bits.
    typedef logic [3:0][coeff_w-1:0] coeff_quad_t;
    typedef logic [3:0][code_w-1:0]  lane_code_t;

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_drain,
        st_wait_pack,
        st_done
    } ctrl_state_e;

endpackage

// File: design/skencode_top.sv
// Top level of the secret-key encoder: controller, two lane
// encoders and the key word packer.

`timescale 1ns/100ps

module skencode_top (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              zeroize,
    input  logic                              enable,
    input  logic [skencode_pkg::addr_w-1:0]   src_base,
    input  logic [skencode_pkg::addr_w-1:0]   dest_base,
    input  skencode_pkg::coeff_quad_t         rd_data_a,
    input  skencode_pkg::coeff_quad_t         rd_data_b,
    output skencode_pkg::mem_req_t            rd_req_a,
    output skencode_pkg::mem_req_t            rd_req_b,
    output skencode_pkg::mem_req_t            wr_req,
    output logic [skencode_pkg::word_w-1:0]   wr_data,
    output logic                              done,
    output logic                              error
);

    skencode_pkg::lane_code_t codes_a;
    skencode_pkg::lane_code_t codes_b;
    logic                     err_a;
    logic                     err_b;
    logic                     data_valid;
    logic                     abort;
    logic                     pack_last;

    // ==================================================
    // Control
    // ==================================================
    skencode_ctrl i_ctrl (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .enable     (enable),
        .src_base   (src_base),
        .err_a      (err_a),
        .err_b      (err_b),
        .pack_last  (pack_last),
        .rd_req_a   (rd_req_a),
        .rd_req_b   (rd_req_b),
        .data_valid (data_valid),
        .abort      (abort),
        .done       (done),
        .error      (error)
    );

    // ==================================================
    // Datapath
    // ==================================================

    // Port A carries the even address of each pair and port B the odd one.
    coeff_lane_encoder i_lane_a (
        .coeffs (rd_data_a),
        .codes  (codes_a),
        .err    (err_a)
    );

    coeff_lane_encoder i_lane_b (
        .coeffs (rd_data_b),
        .codes  (codes_b),
        .err    (err_b)
    );

    key_word_packer i_packer (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .dest_base  (dest_base),
        .data_valid (data_valid),
        .abort      (abort),
        .codes_a    (codes_a),
        .codes_b    (codes_b),
        .wr_req     (wr_req),
        .wr_data    (wr_data),
        .pack_last  (pack_last)
    );

endmodule

// File: dv/skencode_checker.sv
// Checker for the secret-key encoder testbench: read order, key memory
// writes and status pulses, with one report line per test.

`timescale 1ns/100ps

module skencode_checker (
    input  logic                            clk,
    input  skencode_pkg::mem_req_t          rd_req_a,
    input  skencode_pkg::mem_req_t          rd_req_b,
    input  skencode_pkg::mem_req_t          wr_req,
    input  logic [skencode_pkg::word_w-1:0] wr_data,
    input  logic                            done,
    input  logic                            error
);

    logic [skencode_pkg::word_w-1:0] exp_words [0:skencode_pkg::num_wr_words-1];
    logic [8*16-1:0]                 cur_name;
    logic [skencode_pkg::addr_w-1:0] cur_src;
    logic [skencode_pkg::addr_w-1:0] cur_dest;
    bit                              active = 1'b0;
    int                              max_words;
    int                              rd_count;
    int                              wr_count;
    int                              done_count;
    int                              error_count;
    int                              test_errors = 0;
    int                              tests_run = 0;
    int                              tests_failed = 0;
    int                              total_errors = 0;

    task report(input string msg);
        $display("%s", msg);
        test_errors++;
        total_errors++;
    endtask

    task set_expected_word(input int idx, input logic [skencode_pkg::word_w-1:0] word);
        exp_words[idx] = word;
    endtask

    task begin_test(input logic [8*16-1:0] name, input logic [skencode_pkg::addr_w-1:0] src,
                    input logic [skencode_pkg::addr_w-1:0] dest, input int limit);
        cur_name    = name;
        cur_src     = src;
        cur_dest    = dest;
        max_words   = limit;
        rd_count    = 0;
        wr_count    = 0;
        done_count  = 0;
        error_count = 0;
        test_errors = 0;
        active      = 1'b1;
    endtask

    task end_test(input int exp_done, input int exp_error, input bit exp_full);
        if (done_count != exp_done)
            report($sformatf("Mismatch %0s done pulses: expected %0d, actual %0d",
                             cur_name, exp_done, done_count));
        if (error_count != exp_error)
            report($sformatf("Mismatch %0s error pulses: expected %0d, actual %0d",
                             cur_name, exp_error, error_count));
        if (exp_full && wr_count != skencode_pkg::num_wr_words)
            report($sformatf("Mismatch %0s write count: expected %0d, actual %0d",
                             cur_name, skencode_pkg::num_wr_words, wr_count));
        if (exp_full && rd_count != skencode_pkg::num_rd_pairs)
            report($sformatf("Mismatch %0s read pairs: expected %0d, actual %0d",
                             cur_name, skencode_pkg::num_rd_pairs, rd_count));
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %0s: %0d words, %0d read pairs", cur_name, wr_count, rd_count);
        end
        else begin
            tests_failed++;
            $display("FAIL %0s: %0d errors", cur_name, test_errors);
        end
        active = 1'b0;
    endtask

    // After a reset or a zeroize every request port is idle and no status pulse is high.
    task check_idle(input logic [8*16-1:0] label);
        if (rd_req_a.op !== skencode_pkg::mem_idle || rd_req_b.op !== skencode_pkg::mem_idle ||
            wr_req.op !== skencode_pkg::mem_idle || done !== 1'b0 || error !== 1'b0)
            report($sformatf("Request ports or status outputs not idle after %0s", label));
    endtask

    task check_read();
        logic [skencode_pkg::addr_w-1:0] exp_a;
        exp_a = skencode_pkg::addr_w'(cur_src + 2 * rd_count);
        if (!active)
            report("Coefficient read issued while no run was started");
        else if (rd_req_a.op != skencode_pkg::mem_read || rd_req_b.op != skencode_pkg::mem_read)
            report($sformatf("Read ports did not issue together in test %0s", cur_name));
        else if (rd_count >= skencode_pkg::num_rd_pairs)
            report($sformatf("Test %0s issued more read pairs than the image holds", cur_name));
        else begin
            if (rd_req_a.addr !== exp_a)
                report($sformatf("Mismatch %0s read %0d port A: expected %h, actual %h",
                                 cur_name, rd_count, exp_a, rd_req_a.addr));
            if (rd_req_b.addr !== exp_a + 1'b1)
                report($sformatf("Mismatch %0s read %0d port B: expected %h, actual %h",
                                 cur_name, rd_count, exp_a + 1'b1, rd_req_b.addr));
        end
        rd_count++;
    endtask

    task check_write();
        logic [skencode_pkg::addr_w-1:0] exp_addr;
        exp_addr = skencode_pkg::addr_w'(cur_dest + wr_count);
        if (!active)
            report("Key memory write issued while no run was started");
        else if (wr_count >= max_words)
            report($sformatf("Test %0s wrote past its allowed range at address %h",
                             cur_name, wr_req.addr));
        else begin
            if (wr_req.addr !== exp_addr)
                report($sformatf("Mismatch %0s write %0d address: expected %h, actual %h",
                                 cur_name, wr_count, exp_addr, wr_req.addr));
            if (wr_data !== exp_words[wr_count])
                report($sformatf("Mismatch %0s write %0d data: expected %h, actual %h",
                                 cur_name, wr_count, exp_words[wr_count], wr_data));
        end
        wr_count++;
    endtask

    // Outputs are sampled half a cycle after the edge that launched them.
    always @(negedge clk) begin
        if (rd_req_a.op == skencode_pkg::mem_read || rd_req_b.op == skencode_pkg::mem_read)
            check_read();
        if (wr_req.op == skencode_pkg::mem_write)
            check_write();
        if ((done || error) && !active)
            report("Done or error pulse seen while no run was started");
        if (done)
            done_count++;
        if (error)
            error_count++;
    end

endmodule

// File: dv/skencode_tb.sv
// Testbench top for the secret-key encoder: coefficient memory model,
// test table, stimulus loop and watchdog.

`timescale 1ns/100ps

module skencode_tb;

    localparam int num_tests = 8;
    localparam int run_limit = 2000;

    typedef struct packed {
        logic [8*16-1:0]                 name;
        logic [7:0]                      seed_off;
        logic                            zero_fill;
        logic [skencode_pkg::addr_w-1:0] src;
        logic [skencode_pkg::addr_w-1:0] dest;
        logic signed [15:0]              bad_idx;
        logic                            zeroize_mid;
        logic [1:0]                      exp_done;
        logic [1:0]                      exp_error;
    } test_entry_t;

    logic                            clk;
    logic                            reset_n;
    logic                            zeroize;
    logic                            enable;
    logic [skencode_pkg::addr_w-1:0] src_base;
    logic [skencode_pkg::addr_w-1:0] dest_base;
    skencode_pkg::coeff_quad_t       rd_data_a = '0;
    skencode_pkg::coeff_quad_t       rd_data_b = '0;
    skencode_pkg::mem_req_t          rd_req_a;
    skencode_pkg::mem_req_t          rd_req_b;
    skencode_pkg::mem_req_t          wr_req;
    logic [skencode_pkg::word_w-1:0] wr_data;
    logic                            done;
    logic                            error;
    integer                          seed;

    skencode_pkg::coeff_quad_t coeff_mem [0:(1 << skencode_pkg::addr_w) - 1];
    test_entry_t               tests [0:num_tests-1];

    tb_clock_gen i_clk_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    skencode_top i_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .enable    (enable),
        .src_base  (src_base),
        .dest_base (dest_base),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .rd_req_a  (rd_req_a),
        .rd_req_b  (rd_req_b),
        .wr_req    (wr_req),
        .wr_data   (wr_data),
        .done      (done),
        .error     (error)
    );

    skencode_checker i_checker (
        .clk      (clk),
        .rd_req_a (rd_req_a),
        .rd_req_b (rd_req_b),
        .wr_req   (wr_req),
        .wr_data  (wr_data),
        .done     (done),
        .error    (error)
    );

    // Both read ports answer one cycle after the request.
    always @(posedge clk) begin
        if (rd_req_a.op == skencode_pkg::mem_read)
            rd_data_a <= coeff_mem[rd_req_a.addr];
        if (rd_req_b.op == skencode_pkg::mem_read)
            rd_data_b <= coeff_mem[rd_req_b.addr];
    end

    // ==================================================
    // Reference model of the eta = 2 packing
    // ==================================================
    function automatic logic [2:0] eta_code(input logic [skencode_pkg::coeff_w-1:0] c);
        if (c == 0)
            return 3'd2;
        else if (c == 1)
            return 3'd1;
        else if (c == 2)
            return 3'd0;
        else if (c == skencode_pkg::mldsa_q - 1)
            return 3'd3;
        else if (c == skencode_pkg::mldsa_q - 2)
            return 3'd4;
        return 3'd0;
    endfunction

    function automatic logic [skencode_pkg::coeff_w-1:0] legal_coeff(input int sel);
        case (sel)
            0: return 0;
            1: return 1;
            2: return 2;
            3: return skencode_pkg::mldsa_q - 1;
            default: return skencode_pkg::mldsa_q - 2;
        endcase
    endfunction

    task fill_coeffs(input test_entry_t t);
        skencode_pkg::coeff_quad_t q;
        int                        a;
        int                        i;
        seed = 82189 + t.seed_off;
        for (a = 0; a < skencode_pkg::num_rd_addr; a++) begin
            for (i = 0; i < 4; i++)
                q[i] = t.zero_fill ? '0 : legal_coeff($unsigned($random(seed)) % 5);
            coeff_mem[t.src + a] = q;
        end
        if (t.bad_idx >= 0) begin
            q = coeff_mem[t.src + t.bad_idx / 4];
            q[t.bad_idx % 4] = 24'd5;
            coeff_mem[t.src + t.bad_idx / 4] = q;
        end
    endtask

    // String k of a group is {port B codes, port A codes} at buffer bits 24k upward.
    task build_expected(input test_entry_t t);
        logic [95:0]               group_bits;
        skencode_pkg::coeff_quad_t q;
        int                        g;
        int                        s;
        int                        lane;
        int                        i;
        for (g = 0; g < skencode_pkg::num_wr_words / 3; g++) begin
            for (s = 0; s < 4; s++) begin
                for (lane = 0; lane < 2; lane++) begin
                    q = coeff_mem[t.src + 2 * (4 * g + s) + lane];
                    for (i = 0; i < 4; i++)
                        group_bits[24 * s + 12 * lane + 3 * i +: 3] = eta_code(q[i]);
                end
            end
            for (i = 0; i < 3; i++)
                i_checker.set_expected_word(3 * g + i, group_bits[32 * i +: 32]);
        end
    endtask

    // ==================================================
    // Test table and stimulus
    // ==================================================
    task set_entry(input int idx, input logic [8*16-1:0] name, input int seed_off,
                   input bit zero_fill, input int src, input int dest, input int bad_idx,
                   input bit zeroize_mid, input int exp_done, input int exp_error);
        tests[idx].name        = name;
        tests[idx].seed_off    = seed_off;
        tests[idx].zero_fill   = zero_fill;
        tests[idx].src         = src;
        tests[idx].dest        = dest;
        tests[idx].bad_idx     = bad_idx;
        tests[idx].zeroize_mid = zeroize_mid;
        tests[idx].exp_done    = exp_done;
        tests[idx].exp_error   = exp_error;
    endtask

    // Index 1630 sits in the last string of group 50, 1234 in the middle of group 38.
    task load_table();
        set_entry(0, "all_zero",       0, 1, 'h0000, 'h0000,   -1, 0, 1, 0);
        set_entry(1, "random_bases",   1, 0, 'h1234, 'h0456,   -1, 0, 1, 0);
        set_entry(2, "bad_interior",   2, 0, 'h0100, 'h2000, 1234, 0, 0, 1);
        set_entry(3, "bad_group_end",  3, 0, 'h0900, 'h2400, 1630, 0, 0, 1);
        set_entry(4, "back_to_back_a", 4, 0, 'h4000, 'h6000,   -1, 0, 1, 0);
        set_entry(5, "back_to_back_b", 5, 0, 'h03c0, 'h6168,   -1, 0, 1, 0);
        set_entry(6, "zeroize_mid",    6, 0, 'h2a00, 'h1000,   -1, 1, 0, 0);
        set_entry(7, "after_zeroize",  7, 0, 'h2a00, 'h1000,   -1, 0, 1, 0);
    endtask

    task pulse_input(input bit is_zeroize);
        @(posedge clk);
        #1;
        if (is_zeroize)
            zeroize = 1'b1;
        else
            enable = 1'b1;
        @(posedge clk);
        #1;
        zeroize = 1'b0;
        enable  = 1'b0;
    endtask

    task run_test(input test_entry_t t);
        int max_words;
        int cycles;
        fill_coeffs(t);
        build_expected(t);
        // A bad coefficient may still let out the first word of its own group.
        max_words = (t.bad_idx >= 0) ? 3 * (t.bad_idx / 32 + 1) : skencode_pkg::num_wr_words;
        i_checker.begin_test(t.name, t.src, t.dest, max_words);
        @(posedge clk);
        #1;
        src_base  = t.src;
        dest_base = t.dest;
        pulse_input(1'b0);
        if (t.zeroize_mid) begin
            repeat (200) @(posedge clk);
            pulse_input(1'b1);
            @(negedge clk);
            i_checker.check_idle("zeroize");
        end
        else begin
            if (t.bad_idx < 0) begin
                repeat (100) @(posedge clk);
                pulse_input(1'b0);
            end
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
            end while (!done && !error && cycles < run_limit);
            if (!done && !error)
                i_checker.report($sformatf("Test %0s saw neither done nor error in %0d cycles",
                                           t.name, run_limit));
        end
        repeat (8) @(negedge clk);
        i_checker.end_test(t.exp_done, t.exp_error, t.exp_done != 0);
    endtask

    initial begin
        zeroize   = 1'b0;
        enable    = 1'b0;
        src_base  = '0;
        dest_base = '0;
        load_table();
        @(posedge reset_n);
        @(negedge clk);
        i_checker.check_idle("reset");
        for (int t = 0; t < num_tests; t++)
            run_test(tests[t]);
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 i_checker.tests_run, i_checker.tests_failed, i_checker.total_errors);
        if (i_checker.total_errors == 0 && i_checker.tests_run == num_tests)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // Each test is allowed the same cycle budget as the per-run limit.
    initial begin
        repeat (num_tests * run_limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles", num_tests * run_limit);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: dv/tb_clock_gen.sv
// Testbench clock (20 ns period) and active-low reset for 10 cycles.

`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;
    end

endmodule

// File: files.f
design/skencode_pkg.sv
design/coeff_lane_encoder.sv
design/skencode_ctrl.sv
design/key_word_packer.sv
design/skencode_top.sv
dv/tb_clock_gen.sv
dv/skencode_checker.sv
dv/skencode_tb.sv
